// ==== verilog.f ====
rtl/scadPkg.sv
rtl/flagPkg.sv
rtl/scadOperandSelect.sv
rtl/scadSlice.sv
rtl/shiftCountRegs.sv
rtl/pcFlags.sv
rtl/scdTop.sv
testbench/scdTop_checker.sv
testbench/scdTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the SCAD datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module scdTb -f verilog.f -o simScd
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simScd > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "test failed" "$logFile"; then
  exit 1
fi
exit 0

// ==== testbench/scdTb.sv ====
`timescale 1ns/100ps

module scdTb import scadPkg::*, flagPkg::*; ();

  localparam int clkPeriod = 20;
  localparam int driveSkew = 2;
  localparam int resetCycles = 16;
  localparam int testCount = 5;
  localparam int cyclesPerTest = 120;
  localparam int timeoutNs = (resetCycles + testCount * cyclesPerTest) * clkPeriod + 2000;

  logic clk;
  logic rstN;
  logic [funcWidth-1:0] scadFunc;
  logic [scadaSelWidth-1:0] scadaSel;
  logic [scadbSelWidth-1:0] scadbSel;
  logic [0:magicWidth-1] magic;
  logic [0:arWidth-1] ar;
  logic feLoad;
  logic [scmSelWidth-1:0] scmSel;
  logic flagCtl;
  logic setAdFlags;
  logic expTest;
  logic pcfMagic;
  logic clrFpd;
  logic piCycle;
  logic adOverflow;
  logic adCry0;
  logic adCry1;
  logic [0:scadWidth-1] scad;
  logic scadZero;
  logic scadSign;
  logic [0:scadWidth-1] fe;
  logic [0:scadWidth-1] sc;
  logic scGe36;
  logic sc36To63;
  logic [flagCount-1:0] flags;

  logic [0:scadWidth-1] refFe;
  logic [0:scadWidth-1] refSc;
  logic [flagCount-1:0] refFlags;
  logic [0:scadWidth-1] expScad;
  logic [31:0] lfsrState;
  int errors;
  int checks;

  scdTop i_dut (
    .clk(clk),
    .rstN(rstN),
    .scadFunc(scadFunc),
    .scadaSel(scadaSel),
    .scadbSel(scadbSel),
    .magic(magic),
    .ar(ar),
    .feLoad(feLoad),
    .scmSel(scmSel),
    .flagCtl(flagCtl),
    .setAdFlags(setAdFlags),
    .expTest(expTest),
    .pcfMagic(pcfMagic),
    .clrFpd(clrFpd),
    .piCycle(piCycle),
    .adOverflow(adOverflow),
    .adCry0(adCry0),
    .adCry1(adCry1),
    .scad(scad),
    .scadZero(scadZero),
    .scadSign(scadSign),
    .fe(fe),
    .sc(sc),
    .scGe36(scGe36),
    .sc36To63(sc36To63),
    .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(timeoutNs);
    $display("timeout: the tests did not finish within %0d ns", timeoutNs);
    $display("test failed");
    $finish;
  end

  // Galois LFSR, one step per random bit
  function automatic logic [35:0] randomBits(input int n);
    logic [35:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[34:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hD0000001) : (lfsrState >> 1);
    end
    return value;
  endfunction

  function automatic logic [0:scadWidth-1] refScad(
    input logic [funcWidth-1:0]     func,
    input logic [scadaSelWidth-1:0] aSel,
    input logic [scadbSelWidth-1:0] bSel,
    input logic [0:magicWidth-1]    magicIn,
    input logic [0:arWidth-1]       arIn,
    input logic [0:scadWidth-1]     feIn,
    input logic [0:scadWidth-1]     scIn
  );
    logic [0:scadWidth-1] magicExt;
    logic [0:scadWidth-1] a;
    logic [0:scadWidth-1] b;
    logic [0:scadWidth-1] result;
    magicExt = {magicIn[0], magicIn};
    a = '0;
    if (!aSel[2]) begin
      case (aSel[1:0])
        scadaFe:    a = feIn;
        scadaArPos: a = {4'b0000, arIn[0:5]};
        scadaArExp: a = {2'b00, arIn[1:8] ^ {8{arIn[0]}}};
        default:    a = magicExt;
      endcase
    end
    case (bSel)
      scadbSc:     b = scIn;
      scadbArSize: b = {4'b0000, arIn[6:11]};
      scadbArExp:  b = {arIn[0], arIn[0:8]};
      default:     b = magicExt;
    endcase
    case (func)
      funcA:             result = a;
      funcAMinusBMinus1: result = a - b - 10'd1;
      funcAPlusB:        result = a + b;
      funcAMinus1:       result = a - 10'd1;
      funcAPlus1:        result = a + 10'd1;
      funcAMinusB:       result = a - b;
      funcOr:            result = a | b;
      default:           result = a & b;
    endcase
    return result;
  endfunction

  assign expScad = refScad(scadFunc, scadaSel, scadbSel, magic, ar, refFe, refSc);

  function automatic logic [flagCount-1:0] refNextFlags(input logic [flagCount-1:0] cur);
    logic [flagCount-1:0] next;
    logic live;
    next = cur;
    live = !piCycle;
    if (flagCtl && magic[magicLoadFlags]) begin
      next[flagOv] = ar[arOvBit];
      next[flagCry0] = ar[arCry0Bit];
      next[flagCry1] = ar[arCry1Bit];
      next[flagFov] = ar[arFovBit];
      next[flagFpd] = ar[arFpdBit];
      next[flagFxu] = ar[arFxuBit];
      next[flagDivChk] = ar[arDivChkBit];
    end else begin
      if (live && ((setAdFlags && adOverflow) || (expTest && expScad[1])
          || (pcfMagic && magic[magicPcfOv]))) begin
        next[flagOv] = 1'b1;
        next[flagFov] = 1'b1;
      end
      if (live && setAdFlags && adCry0) next[flagCry0] = 1'b1;
      if (live && setAdFlags && adCry1) next[flagCry1] = 1'b1;
      if (live && ((expTest && expScad[0]) || (pcfMagic && magic[magicPcfFxu]))) begin
        next[flagFxu] = 1'b1;
      end
      if (live && pcfMagic && magic[magicPcfDivChk]) next[flagDivChk] = 1'b1;
      if (live && pcfMagic && magic[magicPcfFpd]) begin
        next[flagFpd] = 1'b1;
      end else if (clrFpd) begin
        next[flagFpd] = 1'b0;
      end
    end
    return next;
  endfunction

  // Reference registers
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      refFe <= '0;
      refSc <= '0;
      refFlags <= '0;
    end else begin
      if (feLoad) refFe <= expScad;
      case (scmSel)
        scmFe:   refSc <= refFe;
        scmScad: refSc <= expScad;
        scmAr:   refSc <= {1'b0, ar[18], ar[28:35]};
        default: refSc <= refSc;
      endcase
      refFlags <= refNextFlags(refFlags);
    end
  end

  task automatic reportMismatch(input string what, input logic [35:0] got, input logic [35:0] exp);
    $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    errors++;
  endtask

  task automatic waitDrivePoint();
    @(posedge clk);
    #(driveSkew);
  endtask

  task automatic idleControls();
    scadFunc = funcA;
    scadaSel = 3'b100;
    scadbSel = scadbSc;
    feLoad = 1'b0;
    scmSel = scmHold;
    flagCtl = 1'b0;
    setAdFlags = 1'b0;
    expTest = 1'b0;
    pcfMagic = 1'b0;
    clrFpd = 1'b0;
    piCycle = 1'b0;
    adOverflow = 1'b0;
    adCry0 = 1'b0;
    adCry1 = 1'b0;
  endtask

  // Samples mid-cycle, away from both edges
  task automatic checkOutputs(input string where);
    logic expZero;
    logic expGe36;
    logic exp36To63;
    @(negedge clk);
    checks++;
    expZero = (expScad == 10'd0);
    expGe36 = (refSc >= 10'd64);
    exp36To63 = refSc[4] && (refSc[5:7] != 3'b000);
    if (scad !== expScad) reportMismatch({where, ": scad"}, scad, expScad);
    if (scadZero !== expZero) reportMismatch({where, ": scadZero"}, scadZero, expZero);
    if (scadSign !== expScad[0]) reportMismatch({where, ": scadSign"}, scadSign, expScad[0]);
    if (fe !== refFe) reportMismatch({where, ": fe"}, fe, refFe);
    if (sc !== refSc) reportMismatch({where, ": sc"}, sc, refSc);
    if (scGe36 !== expGe36) reportMismatch({where, ": scGe36"}, scGe36, expGe36);
    if (sc36To63 !== exp36To63) begin
      reportMismatch({where, ": sc36To63"}, sc36To63, exp36To63);
    end
    if (flags !== refFlags) reportMismatch({where, ": flags"}, flags, refFlags);
  endtask

  task automatic loadFeFromMagic(input logic [0:magicWidth-1] value);
    waitDrivePoint();
    idleControls();
    magic = value;
    scadaSel = {1'b0, scadaMagic};
    feLoad = 1'b1;
    checkOutputs("fe load");
  endtask

  task automatic testScadFunctions();
    for (int f = 0; f < 8; f++) begin
      for (int i = 0; i < 4; i++) begin
        loadFeFromMagic(9'(randomBits(9)));
        waitDrivePoint();
        idleControls();
        ar = 36'(randomBits(36));
        scadaSel = {1'b0, scadaFe};
        scadbSel = (i % 2 == 0) ? scadbArExp : scadbArSize;
        scadFunc = 3'(f);
        checkOutputs("scad function");
      end
    end
    // A-B with equal operands gives zero
    waitDrivePoint();
    scadaSel = {1'b0, scadaMagic};
    scadbSel = scadbMagic;
    scadFunc = funcAMinusB;
    checkOutputs("scad zero");
  endtask

  task automatic testOperandSelects();
    loadFeFromMagic(9'(randomBits(9)));
    waitDrivePoint();
    ar = 36'(randomBits(36));
    scmSel = scmAr;
    feLoad = 1'b0;
    checkOutputs("sc setup");
    for (int a = 0; a < 8; a++) begin
      waitDrivePoint();
      idleControls();
      ar = 36'(randomBits(36));
      magic = 9'(randomBits(9));
      scadaSel = 3'(a);
      checkOutputs("a select");
    end
    for (int b = 0; b < 4; b++) begin
      waitDrivePoint();
      ar = 36'(randomBits(36));
      magic = 9'(randomBits(9));
      scadaSel = 3'b100;
      scadbSel = 2'(b);
      scadFunc = funcAPlusB;
      checkOutputs("b select");
    end
  endtask

  task automatic testRegisters();
    logic [8:0] scValues[9];
    scValues = '{9'd0, 9'd35, 9'd36, 9'd40, 9'd63, 9'd64, 9'd100, 9'd300, 9'd511};
    foreach (scValues[i]) begin
      waitDrivePoint();
      idleControls();
      ar = 36'(randomBits(36));
      ar[18] = scValues[i][8];
      ar[28:35] = scValues[i][7:0];
      scmSel = scmAr;
      checkOutputs("sc from ar");
      waitDrivePoint();
      scmSel = scmHold;
      magic = 9'(randomBits(9));
      scadaSel = {1'b0, scadaMagic};
      checkOutputs("sc hold");
    end
    loadFeFromMagic(9'h1C5);
    waitDrivePoint();
    feLoad = 1'b0;
    scmSel = scmFe;
    checkOutputs("sc from fe");
    for (int i = 0; i < 20; i++) begin
      waitDrivePoint();
      idleControls();
      ar = 36'(randomBits(36));
      magic = 9'(randomBits(9));
      scadFunc = 3'(randomBits(3));
      scadaSel = 3'(randomBits(3));
      scadbSel = 2'(randomBits(2));
      scmSel = 2'(randomBits(2));
      feLoad = randomBits(1) == 1;
      checkOutputs("random registers");
    end
  endtask

  task automatic clearFlags();
    waitDrivePoint();
    idleControls();
    ar = '0;
    magic = '0;
    magic[magicLoadFlags] = 1'b1;
    flagCtl = 1'b1;
    checkOutputs("flag clear");
  endtask

  task automatic testFlags();
    for (int i = 0; i < 6; i++) begin
      waitDrivePoint();
      idleControls();
      ar = 36'(randomBits(36));
      magic = 9'(randomBits(9));
      magic[magicLoadFlags] = 1'b1;
      flagCtl = 1'b1;
      checkOutputs("flag load");
    end
    clearFlags();
    waitDrivePoint();
    idleControls();
    setAdFlags = 1'b1;
    adCry0 = 1'b1;
    checkOutputs("set cry0");
    waitDrivePoint();
    adCry0 = 1'b0;
    adOverflow = 1'b1;
    checkOutputs("set overflow");
    clearFlags();
    waitDrivePoint();
    idleControls();
    magic = 9'h180;
    scadaSel = {1'b0, scadaMagic};
    expTest = 1'b1;
    checkOutputs("exponent test");
    // Magic bits 0, 2, 5 and 6 set the PC flags
    waitDrivePoint();
    idleControls();
    magic = 9'h14C;
    pcfMagic = 1'b1;
    checkOutputs("pc flag magic");
    waitDrivePoint();
    idleControls();
    clrFpd = 1'b1;
    checkOutputs("clear fpd");
    waitDrivePoint();
    pcfMagic = 1'b1;
    checkOutputs("fpd set over clear");
    for (int i = 0; i < 24; i++) begin
      waitDrivePoint();
      idleControls();
      ar = 36'(randomBits(36));
      magic = 9'(randomBits(9));
      scadaSel = 3'(randomBits(3));
      flagCtl = randomBits(3) == 0;
      setAdFlags = randomBits(1) == 1;
      expTest = randomBits(1) == 1;
      pcfMagic = randomBits(1) == 1;
      clrFpd = randomBits(1) == 1;
      adOverflow = randomBits(1) == 1;
      adCry0 = randomBits(1) == 1;
      adCry1 = randomBits(1) == 1;
      checkOutputs("random flags");
    end
  endtask

  task automatic testPiCycle();
    clearFlags();
    for (int i = 0; i < 12; i++) begin
      waitDrivePoint();
      idleControls();
      piCycle = 1'b1;
      magic = 9'(randomBits(9));
      scadaSel = {1'b0, scadaMagic};
      setAdFlags = 1'b1;
      expTest = 1'b1;
      pcfMagic = 1'b1;
      adOverflow = 1'b1;
      adCry0 = 1'b1;
      adCry1 = 1'b1;
      checkOutputs("set during pi cycle");
      if (flags !== '0) reportMismatch("flag set during pi cycle", flags, 0);
    end
    waitDrivePoint();
    idleControls();
    piCycle = 1'b1;
    ar = 36'(randomBits(36));
    magic = '0;
    magic[magicLoadFlags] = 1'b1;
    flagCtl = 1'b1;
    checkOutputs("load during pi cycle");
    waitDrivePoint();
    idleControls();
    checkOutputs("after pi cycle load");
  endtask

  initial begin
    lfsrState = 32'd85540;
    errors = 0;
    checks = 0;
    rstN = 1'b0;
    ar = '0;
    magic = '0;
    idleControls();
    repeat (resetCycles) @(posedge clk);
    #(driveSkew);
    rstN = 1'b1;
    checkOutputs("after reset");
    testScadFunctions();
    testOperandSelects();
    testRegisters();
    testFlags();
    testPiCycle();
    waitDrivePoint();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/scdTop_checker.sv ====
`timescale 1ns/100ps

module scdTop_checker import scadPkg::*, flagPkg::*; (
  input logic                   clk,
  input logic                   rstN,
  input logic                   feLoad,
  input logic [scmSelWidth-1:0] scmSel,
  input logic [0:scadWidth-1]   fe,
  input logic [0:scadWidth-1]   sc,
  input logic [flagCount-1:0]   flags
);

  // State after the first edge following release
  resetClears: assert property (@(posedge clk) $rose(rstN) |=> (flags == '0) && (sc == '0))
    else $error("flags or SC not clear after reset release");

  feHolds: assert property (@(posedge clk) disable iff (!rstN) !feLoad |=> $stable(fe))
    else $error("FE changed while feLoad was low");

  scHolds: assert property (@(posedge clk) disable iff (!rstN)
      (scmSel == scmHold) |=> $stable(sc))
    else $error("SC changed while scmSel selected hold");

endmodule

bind scdTop scdTop_checker i_checker (
  .clk(clk),
  .rstN(rstN),
  .feLoad(feLoad),
  .scmSel(scmSel),
  .fe(fe),
  .sc(sc),
  .flags(flags)
);

// ==== rtl/scdTop.sv ====
`timescale 1ns/100ps

module scdTop import scadPkg::*, flagPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [funcWidth-1:0]     scadFunc,
  input  logic [scadaSelWidth-1:0] scadaSel,
  input  logic [scadbSelWidth-1:0] scadbSel,
  input  logic [0:magicWidth-1]    magic,
  input  logic [0:arWidth-1]       ar,
  input  logic                     feLoad,
  input  logic [scmSelWidth-1:0]   scmSel,
  input  logic                     flagCtl,
  input  logic                     setAdFlags,
  input  logic                     expTest,
  input  logic                     pcfMagic,
  input  logic                     clrFpd,
  input  logic                     piCycle,
  input  logic                     adOverflow,
  input  logic                     adCry0,
  input  logic                     adCry1,
  output logic [0:scadWidth-1]     scad,
  output logic                     scadZero,
  output logic                     scadSign,
  output logic [0:scadWidth-1]     fe,
  output logic [0:scadWidth-1]     sc,
  output logic                     scGe36,
  output logic                     sc36To63,
  output logic [flagCount-1:0]     flags
);

  logic [0:scadWidth-1] scada;
  logic [0:scadWidth-1] addend;
  // Ripple chain, carry[0] from the selector, top carry-out unused
  logic [sliceCount:0]  carry;

  scadOperandSelect i_operandSelect (
    .scadFunc(scadFunc),
    .scadaSel(scadaSel),
    .scadbSel(scadbSel),
    .magic(magic),
    .ar(ar),
    .fe(fe),
    .sc(sc),
    .scada(scada),
    .scadb(),
    .addend(addend),
    .carryIn(carry[0])
  );

  // Slice 0 holds the least significant bits, SCAD[8:9]
  for (genvar k = 0; k < sliceCount; k++) begin : g_slice
    scadSlice i_slice (
      .a(scada[scadWidth-sliceWidth*(k+1) +: sliceWidth]),
      .addend(addend[scadWidth-sliceWidth*(k+1) +: sliceWidth]),
      .func(scadFunc),
      .cin(carry[k]),
      .f(scad[scadWidth-sliceWidth*(k+1) +: sliceWidth]),
      .cout(carry[k+1])
    );
  end

  shiftCountRegs i_shiftCountRegs (
    .clk(clk),
    .rstN(rstN),
    .scad(scad),
    .ar(ar),
    .feLoad(feLoad),
    .scmSel(scmSel),
    .fe(fe),
    .sc(sc),
    .scadZero(scadZero),
    .scadSign(scadSign),
    .scGe36(scGe36),
    .sc36To63(sc36To63)
  );

  pcFlags #(.arBits(arWidth), .magicBits(magicWidth)) i_pcFlags (
    .clk(clk),
    .rstN(rstN),
    .magic(magic),
    .ar(ar),
    .flagCtl(flagCtl),
    .setAdFlags(setAdFlags),
    .expTest(expTest),
    .pcfMagic(pcfMagic),
    .clrFpd(clrFpd),
    .piCycle(piCycle),
    .adOverflow(adOverflow),
    .adCry0(adCry0),
    .adCry1(adCry1),
    .scadHigh(scad[0:1]),
    .flags(flags)
  );

endmodule

// ==== rtl/pcFlags.sv ====
`timescale 1ns/100ps

module pcFlags import flagPkg::*; #(
  parameter int arBits = 36,
  parameter int magicBits = 9
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [0:magicBits-1] magic,
  input  logic [0:arBits-1]    ar,
  input  logic                 flagCtl,
  input  logic                 setAdFlags,
  input  logic                 expTest,
  input  logic                 pcfMagic,
  input  logic                 clrFpd,
  input  logic                 piCycle,
  input  logic                 adOverflow,
  input  logic                 adCry0,
  input  logic                 adCry1,
  input  logic [0:1]           scadHigh,
  output logic [flagCount-1:0] flags
);

  logic loadFlags;
  logic setAd;
  logic setExp;
  logic setPcf;
  logic [flagCount-1:0] arFlags;
  logic [flagCount-1:0] setTerms;
  logic [flagCount-1:0] flagsNext;

  assign loadFlags = flagCtl & magic[magicLoadFlags];

  // No flag is set during a PI cycle
  assign setAd = setAdFlags & ~piCycle;
  assign setExp = expTest & ~piCycle;
  assign setPcf = pcfMagic & ~piCycle;

  always_comb begin
    arFlags = '0;
    arFlags[flagOv] = ar[arOvBit];
    arFlags[flagCry0] = ar[arCry0Bit];
    arFlags[flagCry1] = ar[arCry1Bit];
    arFlags[flagFov] = ar[arFovBit];
    arFlags[flagFxu] = ar[arFxuBit];
    arFlags[flagDivChk] = ar[arDivChkBit];
    arFlags[flagFpd] = ar[arFpdBit];
  end

  always_comb begin
    setTerms = '0;
    setTerms[flagOv] = setAd & adOverflow | setExp & scadHigh[1] | setPcf & magic[magicPcfOv];
    setTerms[flagFov] = setTerms[flagOv];
    setTerms[flagCry0] = setAd & adCry0;
    setTerms[flagCry1] = setAd & adCry1;
    setTerms[flagFxu] = setExp & scadHigh[0] | setPcf & magic[magicPcfFxu];
    setTerms[flagDivChk] = setPcf & magic[magicPcfDivChk];
    setTerms[flagFpd] = setPcf & magic[magicPcfFpd];
  end

  always_comb begin
    if (loadFlags) begin
      flagsNext = arFlags;
    end else begin
      flagsNext = flags | setTerms;
      // A set in the same cycle wins over the clear
      flagsNext[flagFpd] = setTerms[flagFpd] | (flags[flagFpd] & ~clrFpd);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

endmodule

// ==== rtl/shiftCountRegs.sv ====
`timescale 1ns/100ps

module shiftCountRegs import scadPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [0:scadWidth-1]   scad,
  input  logic [0:arWidth-1]     ar,
  input  logic                   feLoad,
  input  logic [scmSelWidth-1:0] scmSel,
  output logic [0:scadWidth-1]   fe,
  output logic [0:scadWidth-1]   sc,
  output logic                   scadZero,
  output logic                   scadSign,
  output logic                   scGe36,
  output logic                   sc36To63
);

  logic [0:scadWidth-1] scm;

  // SCM source selector for the step counter
  always_comb begin
    case (scmSel)
      scmHold: scm = sc;
      scmFe:   scm = fe;
      scmScad: scm = scad;
      scmAr:   scm = {1'b0, ar[18], ar[28:35]};
      default: scm = sc;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fe <= '0;
    end else if (feLoad) begin
      fe <= scad;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sc <= '0;
    end else begin
      sc <= scm;
    end
  end

  assign scadZero = (scad == '0);
  assign scadSign = scad[0];

  // Range decodes from the registered count
  assign scGe36 = |sc[0:3];
  assign sc36To63 = sc[4] & |sc[5:7];

endmodule

// ==== rtl/scadSlice.sv ====
`timescale 1ns/100ps

module scadSlice import scadPkg::*; (
  input  logic [sliceWidth-1:0] a,
  input  logic [sliceWidth-1:0] addend,
  input  logic [funcWidth-1:0]  func,
  input  logic                  cin,
  output logic [sliceWidth-1:0] f,
  output logic                  cout
);

  logic [sliceWidth:0] sum;

  assign sum = {1'b0, a} + {1'b0, addend} + {{sliceWidth{1'b0}}, cin};

  always_comb begin
    case (func)
      funcOr: begin
        f = a | addend;
        cout = 1'b0;
      end
      funcAnd: begin
        f = a & addend;
        cout = 1'b0;
      end
      default: begin
        // Arithmetic functions differ only in addend and carry-in
        f = sum[sliceWidth-1:0];
        cout = sum[sliceWidth];
      end
    endcase
  end

endmodule

// ==== rtl/scadOperandSelect.sv ====
`timescale 1ns/100ps

module scadOperandSelect import scadPkg::*; (
  input  logic [funcWidth-1:0]     scadFunc,
  input  logic [scadaSelWidth-1:0] scadaSel,
  input  logic [scadbSelWidth-1:0] scadbSel,
  input  logic [0:magicWidth-1]    magic,
  input  logic [0:arWidth-1]       ar,
  input  logic [0:scadWidth-1]     fe,
  input  logic [0:scadWidth-1]     sc,
  output logic [0:scadWidth-1]     scada,
  output logic [0:scadWidth-1]     scadb,
  output logic [0:scadWidth-1]     addend,
  output logic                     carryIn
);

  logic [0:scadWidth-1] magicExt;
  logic [0:7] arExp;

  // Magic number sign-extended from bit 0
  assign magicExt = {magic[0], magic};

  // Exponent magnitude, ones-complemented for negative AR
  assign arExp = ar[1:8] ^ {8{ar[0]}};

  always_comb begin
    scada = '0;
    if (!scadaSel[scadaSelWidth-1]) begin
      case (scadaSel[1:0])
        scadaFe:    scada = fe;
        scadaArPos: scada = {4'b0, ar[0:5]};
        scadaArExp: scada = {2'b0, arExp};
        scadaMagic: scada = magicExt;
        default:    scada = '0;
      endcase
    end
  end

  always_comb begin
    case (scadbSel)
      scadbSc:     scadb = sc;
      scadbArSize: scadb = {4'b0, ar[6:11]};
      scadbArExp:  scadb = {ar[0], ar[0:8]};
      scadbMagic:  scadb = magicExt;
      default:     scadb = sc;
    endcase
  end

  // Slice addend, and the single carry-in decode for the ripple chain
  always_comb begin
    case (scadFunc)
      funcA:             addend = '0;
      funcAMinusBMinus1: addend = ~scadb;
      funcAPlusB:        addend = scadb;
      funcAMinus1:       addend = '1;
      funcAPlus1:        addend = '0;
      funcAMinusB:       addend = ~scadb;
      default:           addend = scadb;
    endcase
  end

  assign carryIn = (scadFunc == funcAPlus1) || (scadFunc == funcAMinusB);

endmodule

// ==== rtl/flagPkg.sv ====
package flagPkg;

  localparam int flagCount = 7;

  // Positions in the flags vector
  localparam int flagOv = 0;
  localparam int flagCry0 = 1;
  localparam int flagCry1 = 2;
  localparam int flagFov = 3;
  localparam int flagFxu = 4;
  localparam int flagDivChk = 5;
  localparam int flagFpd = 6;

  // AR bits that flags load from, bit 0 is the MSB
  localparam int arOvBit = 0;
  localparam int arCry0Bit = 1;
  localparam int arCry1Bit = 2;
  localparam int arFovBit = 3;
  localparam int arFpdBit = 4;
  localparam int arFxuBit = 11;
  localparam int arDivChkBit = 12;

  // Magic field bits used by flag control
  localparam int magicLoadFlags = 4;
  localparam int magicPcfOv = 0;
  localparam int magicPcfFpd = 2;
  localparam int magicPcfFxu = 5;
  localparam int magicPcfDivChk = 6;

endpackage

// ==== rtl/scadPkg.sv ====
package scadPkg;

  // Datapath widths
  localparam int scadWidth = 10;
  localparam int sliceWidth = 2;
  localparam int sliceCount = scadWidth / sliceWidth;
  localparam int arWidth = 36;
  localparam int magicWidth = 9;

  // Microcode field widths
  localparam int funcWidth = 3;
  localparam int scadaSelWidth = 3;
  localparam int scadbSelWidth = 2;
  localparam int scmSelWidth = 2;

  // SCAD function codes
  localparam logic [funcWidth-1:0] funcA = 3'd0;
  localparam logic [funcWidth-1:0] funcAMinusBMinus1 = 3'd1;
  localparam logic [funcWidth-1:0] funcAPlusB = 3'd2;
  localparam logic [funcWidth-1:0] funcAMinus1 = 3'd3;
  localparam logic [funcWidth-1:0] funcAPlus1 = 3'd4;
  localparam logic [funcWidth-1:0] funcAMinusB = 3'd5;
  localparam logic [funcWidth-1:0] funcOr = 3'd6;
  localparam logic [funcWidth-1:0] funcAnd = 3'd7;

  // A select, low two bits; the top bit of scadaSel forces A to zero
  localparam logic [1:0] scadaFe = 2'd0;
  localparam logic [1:0] scadaArPos = 2'd1;
  localparam logic [1:0] scadaArExp = 2'd2;
  localparam logic [1:0] scadaMagic = 2'd3;

  // B select
  localparam logic [scadbSelWidth-1:0] scadbSc = 2'd0;
  localparam logic [scadbSelWidth-1:0] scadbArSize = 2'd1;
  localparam logic [scadbSelWidth-1:0] scadbArExp = 2'd2;
  localparam logic [scadbSelWidth-1:0] scadbMagic = 2'd3;

  // SC source select
  localparam logic [scmSelWidth-1:0] scmHold = 2'd0;
  localparam logic [scmSelWidth-1:0] scmFe = 2'd1;
  localparam logic [scmSelWidth-1:0] scmScad = 2'd2;
  localparam logic [scmSelWidth-1:0] scmAr = 2'd3;

  localparam int scThreshold36 = 36;

endpackage
